//--- build.f
gemv_ctrl_pkg.sv
gemv_data_pkg.sv
tile_bridge.sv
operand_store.sv
row_mac.sv
result_packer.sv
gemv_exec_top.sv
tb_tile_memory.sv
tb_gemv_exec.sv

//--- gemv_ctrl_pkg.sv
// State and opcode encodings for the GEMV control logic; import where an FSM or beat kind is decoded
`default_nettype none

package gemv_ctrl_pkg;

    // ============================
    // Beat opcodes
    // ============================

    // Which operand a compute tile carries
    typedef enum logic [1:0] {
        beat_x,
        beat_bias,
        beat_w
    } beat_kind_e;

    // ============================
    // FSM states
    // ============================

    // Operand streamer where load states wait on memory and stream states emit beats
    typedef enum logic [2:0] {
        idle,
        load_x,
        stream_x,
        load_b,
        stream_b,
        load_w,
        feed_w
    } bridge_state_e;

    // Result packer
    typedef enum logic [1:0] {
        collect,
        write,
        shift
    } packer_state_e;

endpackage

`default_nettype wire

//--- gemv_data_pkg.sv
// Data types and sizes shared by every GEMV engine block; import inside each module body
`default_nettype none

package gemv_data_pkg;

    // ============================
    // Sizes
    // ============================

    // Element width in bits
    localparam int data_w = 8;
    // Elements per buffer tile, the unit of every memory access
    localparam int tile_elems = 8;
    // Elements per compute tile fed to the MAC
    localparam int gemv_tile = 3;
    // Largest rows or cols accepted by a job
    localparam int max_dim = 64;
    localparam int dim_w = 7;
    // Wide enough for 64 products of two 8-bit values plus bias
    localparam int acc_w = 24;

    // ============================
    // Types
    // ============================

    typedef logic signed [data_w-1:0] elem_t;
    typedef elem_t [tile_elems-1:0] buf_tile_t;
    typedef elem_t [gemv_tile-1:0] gemv_tile_t;
    typedef logic [dim_w-1:0] dim_t;

    // One compute tile on the bridge to store/MAC link
    typedef struct packed {
        gemv_ctrl_pkg::beat_kind_e kind;
        dim_t idx;          // compute tile index within its vector or row
        gemv_tile_t tile;
        logic row_last;
        logic job_last;
    } gemv_beat_t;

    // One result element from the MAC
    typedef struct packed {
        elem_t value;
        logic last;
    } y_beat_t;

endpackage

`default_nettype wire

//--- gemv_exec_top.sv
// GEMV engine top level that connects streamer, operand store, MAC and packer to the buffer ports
`default_nettype none

module gemv_exec_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start,
    input  gemv_data_pkg::dim_t      rows,
    input  gemv_data_pkg::dim_t      cols,
    output logic                     done,
    output logic                     vec_read_en,
    input  logic                     vec_read_valid,
    input  gemv_data_pkg::buf_tile_t vec_read_tile,
    output logic                     mat_read_en,
    input  logic                     mat_read_valid,
    input  gemv_data_pkg::buf_tile_t mat_read_tile,
    output logic                     vec_write_en,
    output gemv_data_pkg::buf_tile_t vec_write_tile
);
    import gemv_data_pkg::*;

    // Beat link
    gemv_beat_t beat;
    logic       beat_valid;
    logic       w_ready;
    // Operand lookup
    dim_t       x_idx;
    dim_t       row;
    gemv_tile_t x_tile;
    elem_t      row_bias;
    // Result link
    y_beat_t    y;
    logic       y_valid;

    tile_bridge bridge_i (
        .clk(clk),
        .rst(rst),
        .start(start),
        .rows(rows),
        .cols(cols),
        .vec_read_en(vec_read_en),
        .vec_read_valid(vec_read_valid),
        .vec_read_tile(vec_read_tile),
        .mat_read_en(mat_read_en),
        .mat_read_valid(mat_read_valid),
        .mat_read_tile(mat_read_tile),
        .w_ready(w_ready),
        .beat(beat),
        .beat_valid(beat_valid)
    );

    operand_store store_i (
        .clk(clk),
        .rst(rst),
        .beat(beat),
        .beat_valid(beat_valid),
        .x_idx(x_idx),
        .row(row),
        .x_tile(x_tile),
        .row_bias(row_bias)
    );

    row_mac mac_i (
        .clk(clk),
        .rst(rst),
        .beat(beat),
        .beat_valid(beat_valid),
        .w_ready(w_ready),
        .x_idx(x_idx),
        .row(row),
        .x_tile(x_tile),
        .row_bias(row_bias),
        .y(y),
        .y_valid(y_valid)
    );

    result_packer packer_i (
        .clk(clk),
        .rst(rst),
        .y(y),
        .y_valid(y_valid),
        .vec_write_en(vec_write_en),
        .vec_write_tile(vec_write_tile),
        .done(done)
    );

endmodule

`default_nettype wire

//--- operand_store.sv
// Holds x and bias for a whole job; written by bridge beats, read combinationally by the MAC
`default_nettype none

module operand_store (
    input  logic                      clk,
    input  logic                      rst,
    input  gemv_data_pkg::gemv_beat_t beat,
    input  logic                      beat_valid,
    input  gemv_data_pkg::dim_t       x_idx,
    input  gemv_data_pkg::dim_t       row,
    output gemv_data_pkg::gemv_tile_t x_tile,
    output gemv_data_pkg::elem_t      row_bias
);
    import gemv_data_pkg::*;
    import gemv_ctrl_pkg::*;

    elem_t [max_dim-1:0] x_mem;
    elem_t [max_dim-1:0] b_mem;

    // Beat idx counts compute tiles, element address is idx times 3
    always_ff @(posedge clk or posedge rst) begin
        int pos;
        if (rst) begin
            x_mem <= '0;
            b_mem <= '0;
        end else if (beat_valid) begin
            for (int i = 0; i < gemv_tile; i++) begin
                pos = int'(beat.idx) * gemv_tile + i;
                // Last compute tile of a 64-long vector runs past the array
                if (pos < max_dim) begin
                    if (beat.kind == beat_x) begin
                        x_mem[pos] <= beat.tile[i];
                    end else if (beat.kind == beat_bias) begin
                        b_mem[pos] <= beat.tile[i];
                    end
                end
            end
        end
    end

    // One x compute tile by index, one bias element by row
    always_comb begin
        int pos;
        for (int i = 0; i < gemv_tile; i++) begin
            pos = int'(x_idx) * gemv_tile + i;
            x_tile[i] = (pos < max_dim) ? x_mem[pos] : '0;
        end
        row_bias = (int'(row) < max_dim) ? b_mem[row[$clog2(max_dim)-1:0]] : '0;
    end

endmodule

`default_nettype wire

//--- result_packer.sv
// Packs y elements into buffer tiles, writes each one back and signals job completion
`default_nettype none

module result_packer (
    input  logic                      clk,
    input  logic                      rst,
    input  gemv_data_pkg::y_beat_t    y,
    input  logic                      y_valid,
    output logic                      vec_write_en,
    output gemv_data_pkg::buf_tile_t  vec_write_tile,
    output logic                      done
);
    import gemv_data_pkg::*;
    import gemv_ctrl_pkg::*;

    packer_state_e state;
    buf_tile_t     tile;
    logic [2:0]    pos;        // next free lane
    logic          last_pend;  // tile being written closes the job

    assign vec_write_en = (state == write);
    assign vec_write_tile = tile;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= collect;
            tile <= '0;
            pos <= '0;
            last_pend <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                collect: begin
                    if (y_valid) begin
                        tile[pos] <= y.value;
                        pos <= pos + 1'b1;
                        // Full tile or job end
                        if (pos == 3'(tile_elems - 1) || y.last) begin
                            last_pend <= y.last;
                            state <= write;
                        end
                    end
                end
                write: begin
                    done <= last_pend;
                    state <= shift;
                end
                shift: begin
                    // Unused lanes of the next tile read as zero
                    tile <= '0;
                    pos <= '0;
                    last_pend <= 1'b0;
                    state <= collect;
                end
                default: state <= collect;
            endcase
        end
    end

    // A y arriving during a write or shift would be dropped
    a_y_in_collect: assert property (@(posedge clk) disable iff (rst)
        y_valid |-> state == collect);

endmodule

`default_nettype wire

//--- row_mac.sv
// Two-stage multiply-accumulate over weight beats; adds the row bias and emits one y per row
`default_nettype none

module row_mac (
    input  logic                      clk,
    input  logic                      rst,
    input  gemv_data_pkg::gemv_beat_t beat,
    input  logic                      beat_valid,
    output logic                      w_ready,
    output gemv_data_pkg::dim_t       x_idx,
    output gemv_data_pkg::dim_t       row,
    input  gemv_data_pkg::gemv_tile_t x_tile,
    input  gemv_data_pkg::elem_t      row_bias,
    output gemv_data_pkg::y_beat_t    y,
    output logic                      y_valid
);
    import gemv_data_pkg::*;
    import gemv_ctrl_pkg::*;

    logic signed [2*data_w-1:0] prod [gemv_tile];
    logic                       p1_valid;
    logic                       p1_row_last;
    logic                       p1_job_last;
    logic signed [acc_w-1:0]    acc;
    logic signed [acc_w-1:0]    acc_sum;
    logic signed [acc_w-1:0]    y_full;
    logic                       w_fire;

    // Stall while a row end drains through bias add
    assign w_ready = !(p1_valid && p1_row_last) && !y_valid;
    assign w_fire = beat_valid && (beat.kind == beat_w) && w_ready;
    // x lookup follows the beat on the link
    assign x_idx = beat.idx;

    // ============================
    // Stage 1 products
    // ============================

    always_ff @(posedge clk) begin
        for (int i = 0; i < gemv_tile; i++) begin
            prod[i] <= beat.tile[i] * x_tile[i];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            p1_valid <= 1'b0;
            p1_row_last <= 1'b0;
            p1_job_last <= 1'b0;
        end else begin
            p1_valid <= w_fire;
            p1_row_last <= w_fire && beat.row_last;
            p1_job_last <= w_fire && beat.job_last;
        end
    end

    // ============================
    // Stage 2 accumulate
    // ============================

    always_comb begin
        acc_sum = acc;
        for (int i = 0; i < gemv_tile; i++) begin
            acc_sum = acc_sum + acc_w'(prod[i]);
        end
        y_full = acc_sum + acc_w'(row_bias);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc <= '0;
            row <= '0;
            y <= '0;
            y_valid <= 1'b0;
        end else begin
            y_valid <= 1'b0;
            if (p1_valid) begin
                if (p1_row_last) begin
                    // Wrap to 8 bits, clear for next row
                    y.value <= y_full[data_w-1:0];
                    y.last <= p1_job_last;
                    y_valid <= 1'b1;
                    acc <= '0;
                    row <= p1_job_last ? '0 : row + 1'b1;
                end else begin
                    acc <= acc_sum;
                end
            end
        end
    end

    // Bridge must honour back-pressure on weights
    a_no_w_stall: assert property (@(posedge clk) disable iff (rst)
        (beat_valid && beat.kind == beat_w) |-> w_ready);

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# Builds the GEMV testbench with Verilator, runs it and checks for the pass line
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    --top-module tb_gemv_exec -f build.f
output="$(./obj_dir/Vtb_gemv_exec)"
echo "$output"
if echo "$output" | grep -q "Done: no errors"; then
    exit 0
fi
exit 1

//--- tb_gemv_exec.sv
// GEMV engine testbench top; random jobs checked against a reference model, run by run.sh
`default_nettype none

module tb_gemv_exec;
    timeunit 1ns;
    timeprecision 100ps;
    import gemv_data_pkg::*;

    localparam int timeout_cycles = 20000;
    localparam logic [31:0] seed = 32'h88fe5f43;

    typedef struct packed {
        dim_t rows;
        dim_t cols;
    } job_dims_t;

    logic       clk;
    logic       rst = 1'b1;
    logic       start = 1'b0;
    dim_t       rows = dim_t'(1);
    dim_t       cols = dim_t'(1);
    logic [1:0] delay_pick = 2'd0;
    logic       done;
    logic       vec_read_en;
    logic       vec_read_valid;
    buf_tile_t  vec_read_tile;
    logic       mat_read_en;
    logic       mat_read_valid;
    buf_tile_t  mat_read_tile;
    logic       vec_write_en;
    buf_tile_t  vec_write_tile;

    logic [31:0] stim_rng = seed;
    logic [31:0] lat_rng = ~seed;
    int          mismatches = 0;
    int          failures = 0;
    int          jobs_run = 0;
    logic        timed_out = 1'b0;

    // Operands of the current job and the expected write-back
    elem_t     x_val [max_dim];
    elem_t     b_val [max_dim];
    elem_t     w_val [max_dim][max_dim];
    buf_tile_t exp_tiles [8];

    gemv_exec_top dut_i (
        .clk(clk),
        .rst(rst),
        .start(start),
        .rows(rows),
        .cols(cols),
        .done(done),
        .vec_read_en(vec_read_en),
        .vec_read_valid(vec_read_valid),
        .vec_read_tile(vec_read_tile),
        .mat_read_en(mat_read_en),
        .mat_read_valid(mat_read_valid),
        .mat_read_tile(mat_read_tile),
        .vec_write_en(vec_write_en),
        .vec_write_tile(vec_write_tile)
    );

    tb_tile_memory mem_i (
        .clk(clk),
        .rst(rst),
        .start(start),
        .delay_pick(delay_pick),
        .vec_read_en(vec_read_en),
        .vec_read_valid(vec_read_valid),
        .vec_read_tile(vec_read_tile),
        .mat_read_en(mat_read_en),
        .mat_read_valid(mat_read_valid),
        .mat_read_tile(mat_read_tile),
        .vec_write_en(vec_write_en),
        .vec_write_tile(vec_write_tile)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ==============================
    // Random numbers
    // ==============================

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int pick(input int range);
        stim_rng = lcg_step(stim_rng);
        return int'(stim_rng[30:16]) % range;
    endfunction

    // Keep cols off both tile grids so carries cross buffer tiles
    function automatic dim_t pick_cols();
        dim_t c;
        c = dim_t'(pick(max_dim) + 1);
        while (int'(c) % gemv_tile == 0 || int'(c) % tile_elems == 0) begin
            c = dim_t'(pick(max_dim) + 1);
        end
        return c;
    endfunction

    function automatic job_dims_t make_job(input int r, input int c);
        job_dims_t job;
        job.rows = dim_t'(r);
        job.cols = dim_t'(c);
        return job;
    endfunction

    // Read latency changes every cycle and the memory samples it per request
    always @(posedge clk) begin
        lat_rng <= lcg_step(lat_rng);
        delay_pick <= lat_rng[17:16];
    end

    // ==============================
    // Compare tasks
    // ==============================

    task automatic check_tile(input string name, input buf_tile_t exp, input buf_tile_t act);
        if (act !== exp) begin
            mismatches++;
            $display("MISMATCH %s: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input dim_t exp, input dim_t act);
        if (act !== exp) begin
            mismatches++;
            $display("MISMATCH %s: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            mismatches++;
            $display("MISMATCH %s: expected %h, got %h", name, exp, act);
        end
    endtask

    // ==============================
    // Job setup and reference model
    // ==============================

    task automatic load_job(input job_dims_t job);
        int        n_xt;
        int        n_bt;
        int        acc;
        elem_t     y_exp [max_dim];
        buf_tile_t t;
        n_xt = (int'(job.cols) + tile_elems - 1) / tile_elems;
        n_bt = (int'(job.rows) + tile_elems - 1) / tile_elems;
        // Fresh values everywhere, so lanes past cols and rows hold garbage
        for (int i = 0; i < max_dim; i++) begin
            x_val[i] = elem_t'(pick(256));
            b_val[i] = elem_t'(pick(256));
            for (int j = 0; j < max_dim; j++) begin
                w_val[i][j] = elem_t'(pick(256));
            end
        end
        // Vector source holds x tiles and then bias tiles
        for (int k = 0; k < n_xt; k++) begin
            for (int e = 0; e < tile_elems; e++) begin
                t[e] = x_val[k*tile_elems+e];
            end
            mem_i.vec_mem[k] = t;
        end
        for (int k = 0; k < n_bt; k++) begin
            for (int e = 0; e < tile_elems; e++) begin
                t[e] = b_val[k*tile_elems+e];
            end
            mem_i.vec_mem[n_xt+k] = t;
        end
        // Every matrix row starts on a fresh tile
        for (int r = 0; r < int'(job.rows); r++) begin
            for (int k = 0; k < n_xt; k++) begin
                for (int e = 0; e < tile_elems; e++) begin
                    t[e] = w_val[r][k*tile_elems+e];
                end
                mem_i.mat_mem[r*n_xt+k] = t;
            end
        end
        // Low 8 bits of dot product plus bias with zeros past the last row
        for (int r = 0; r < max_dim; r++) begin
            acc = int'(b_val[r]);
            for (int c = 0; c < int'(job.cols); c++) begin
                acc += int'(w_val[r][c]) * int'(x_val[c]);
            end
            y_exp[r] = (r < int'(job.rows)) ? elem_t'(acc) : elem_t'(0);
        end
        for (int tt = 0; tt < 8; tt++) begin
            for (int e = 0; e < tile_elems; e++) begin
                exp_tiles[tt][e] = y_exp[tt*tile_elems+e];
            end
        end
    endtask

    task automatic run_job(input job_dims_t job);
        int   cycles;
        int   done_count;
        dim_t n_wr;
        load_job(job);
        n_wr = dim_t'((int'(job.rows) + tile_elems - 1) / tile_elems);
        @(posedge clk);
        start <= 1'b1;
        rows <= job.rows;
        cols <= job.cols;
        @(posedge clk);
        start <= 1'b0;
        cycles = 0;
        done_count = 0;
        while (done_count == 0 && cycles < timeout_cycles) begin
            @(negedge clk);
            cycles++;
            if (done) begin
                done_count++;
                // done must follow the final write
                check_count("vec_write_en count at done", n_wr, dim_t'(mem_i.wr_count));
            end
        end
        if (done_count == 0) begin
            failures++;
            timed_out = 1'b1;
            $display("Job with rows %0d and cols %0d raised no done within %0d cycles",
                     job.rows, job.cols, timeout_cycles);
        end else begin
            // No second done and no stray write in the quiet tail
            repeat (4) begin
                @(negedge clk);
                if (done) begin
                    done_count++;
                end
            end
            check_count("done pulses", dim_t'(1), dim_t'(done_count));
            check_count("vec_write_en count", n_wr, dim_t'(mem_i.wr_count));
            for (int tt = 0; tt < int'(n_wr); tt++) begin
                check_tile($sformatf("vec_write_tile[%0d]", tt), exp_tiles[tt],
                           mem_i.wr_tiles[tt]);
            end
            jobs_run++;
        end
    endtask

    // ==============================
    // Main sequence
    // ==============================

    initial begin
        job_dims_t jobs [$];
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        // Outputs stay quiet between reset and the first start
        repeat (5) begin
            @(negedge clk);
            check_flag("done", 1'b0, done);
            check_flag("vec_read_en", 1'b0, vec_read_en);
            check_flag("mat_read_en", 1'b0, mat_read_en);
            check_flag("vec_write_en", 1'b0, vec_write_en);
        end
        for (int n = 0; n < 12; n++) begin
            jobs.push_back(make_job(pick(max_dim) + 1, int'(pick_cols())));
        end
        // Edge sizes
        jobs.push_back(make_job(1, 1));
        jobs.push_back(make_job(max_dim, max_dim));
        jobs.push_back(make_job(1, max_dim));
        jobs.push_back(make_job(max_dim, 1));
        // Jobs run back to back with no reset in between
        foreach (jobs[i]) begin
            if (!timed_out) begin
                run_job(jobs[i]);
            end
        end
        $display("Summary: %0d jobs run, %0d mismatches, %0d other failures",
                 jobs_run, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb_tile_memory.sv
// Tile buffer model for the GEMV testbench; in-order reads after a random delay, writes captured
`default_nettype none

module tb_tile_memory (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start,
    input  logic [1:0]               delay_pick,
    input  logic                     vec_read_en,
    output logic                     vec_read_valid,
    output gemv_data_pkg::buf_tile_t vec_read_tile,
    input  logic                     mat_read_en,
    output logic                     mat_read_valid,
    output gemv_data_pkg::buf_tile_t mat_read_tile,
    input  logic                     vec_write_en,
    input  gemv_data_pkg::buf_tile_t vec_write_tile
);
    timeunit 1ns;
    timeprecision 100ps;
    import gemv_data_pkg::*;

    // Filled by the testbench top before each job
    buf_tile_t  vec_mem [16];
    buf_tile_t  mat_mem [max_dim*8];
    // Written tiles in arrival order
    buf_tile_t  wr_tiles [8];
    logic [3:0] wr_count;
    logic [3:0] vec_ptr;
    logic [8:0] mat_ptr;
    // Cycles left until the pending read answers
    logic [2:0] vec_wait;
    logic [2:0] mat_wait;
    logic       vec_valid_q = 1'b0;
    logic       mat_valid_q = 1'b0;
    buf_tile_t  vec_tile_q = '0;
    buf_tile_t  mat_tile_q = '0;

    assign vec_read_valid = vec_valid_q;
    assign vec_read_tile = vec_tile_q;
    assign mat_read_valid = mat_valid_q;
    assign mat_read_tile = mat_tile_q;

    always @(posedge clk) begin
        vec_valid_q <= 1'b0;
        mat_valid_q <= 1'b0;
        // Each job reads both sources from the top
        if (rst || start) begin
            vec_ptr <= '0;
            mat_ptr <= '0;
            wr_count <= '0;
            vec_wait <= '0;
            mat_wait <= '0;
        end else begin
            // Delay of 1 to 4 cycles per request
            if (vec_read_en) begin
                vec_wait <= {1'b0, delay_pick} + 3'd1;
            end else if (vec_wait != 3'd0) begin
                vec_wait <= vec_wait - 3'd1;
                if (vec_wait == 3'd1) begin
                    vec_valid_q <= 1'b1;
                    vec_tile_q <= vec_mem[vec_ptr];
                    vec_ptr <= vec_ptr + 4'd1;
                end
            end
            if (mat_read_en) begin
                mat_wait <= {1'b0, delay_pick} + 3'd1;
            end else if (mat_wait != 3'd0) begin
                mat_wait <= mat_wait - 3'd1;
                if (mat_wait == 3'd1) begin
                    mat_valid_q <= 1'b1;
                    mat_tile_q <= mat_mem[mat_ptr];
                    mat_ptr <= mat_ptr + 9'd1;
                end
            end
            // Extra writes still count although only the first 8 are kept
            if (vec_write_en) begin
                if (wr_count < 4'd8) begin
                    wr_tiles[wr_count[2:0]] <= vec_write_tile;
                end
                wr_count <= wr_count + 4'd1;
            end
        end
    end

endmodule

`default_nettype wire

//--- tile_bridge.sv
// Operand streamer that reads buffer tiles in order and recuts them into zero-padded compute beats
`default_nettype none

module tile_bridge (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    input  gemv_data_pkg::dim_t       rows,
    input  gemv_data_pkg::dim_t       cols,
    output logic                      vec_read_en,
    input  logic                      vec_read_valid,
    input  gemv_data_pkg::buf_tile_t  vec_read_tile,
    output logic                      mat_read_en,
    input  logic                      mat_read_valid,
    input  gemv_data_pkg::buf_tile_t  mat_read_tile,
    input  logic                      w_ready,
    output gemv_data_pkg::gemv_beat_t beat,
    output logic                      beat_valid
);
    import gemv_data_pkg::*;
    import gemv_ctrl_pkg::*;

    bridge_state_e state;
    buf_tile_t     local_tile;
    logic [3:0]    buf_idx;      // next unread lane of local_tile
    elem_t [1:0]   carry;        // tail of the previous buffer tile
    logic [1:0]    carry_cnt;
    dim_t          bt_read;      // buffer tiles loaded for current vector or row
    dim_t          ct_idx;       // compute tile index within current vector or row
    dim_t          w_row;
    logic          outstanding;

    dim_t       vec_len;
    dim_t       n_ct;
    dim_t       n_bt;
    logic       last_bt;
    logic       ct_last;
    logic       can_send;
    logic       need_tile;
    logic [3:0] avail;
    logic [3:0] new_buf_idx;
    gemv_tile_t built;

    // ============================
    // Position bookkeeping
    // ============================

    // Bias vector is rows long, x and each weight row are cols long
    assign vec_len = (state == load_b || state == stream_b) ? rows : cols;
    assign n_ct = (vec_len + dim_t'(gemv_tile - 1)) / dim_t'(gemv_tile);
    assign n_bt = (vec_len + dim_t'(tile_elems - 1)) >> 3;
    assign last_bt = (bt_read == n_bt);
    assign ct_last = (dim_t'(ct_idx + 1'b1) == n_ct);
    assign avail = {2'b00, carry_cnt} + (4'(tile_elems) - buf_idx);
    assign new_buf_idx = buf_idx + 4'(gemv_tile) - {2'b00, carry_cnt};

    // Once the last buffer tile is in, short tiles go out padded
    assign can_send = (avail >= 4'(gemv_tile)) || last_bt;
    // Weight beats only offered while the MAC can take them
    assign beat_valid = (state == stream_x || state == stream_b ||
                         (state == feed_w && w_ready)) && can_send;

    // Fewer than a full compute tile left and more memory to read
    assign need_tile = beat_valid && !ct_last && !last_bt &&
                       (new_buf_idx > 4'(tile_elems - gemv_tile));

    // Carry lanes first, then local lanes, zero past the vector end
    always_comb begin
        int src;
        int pos;
        for (int i = 0; i < gemv_tile; i++) begin
            src = int'(buf_idx) + i - int'(carry_cnt);
            pos = int'(ct_idx) * gemv_tile + i;
            if (pos >= int'(vec_len)) begin
                built[i] = '0;
            end else if (i < int'(carry_cnt)) begin
                built[i] = carry[1'(i)];
            end else if (src < tile_elems) begin
                built[i] = local_tile[src];
            end else begin
                built[i] = '0;
            end
        end
    end

    always_comb begin
        case (state)
            stream_x: beat.kind = beat_x;
            stream_b: beat.kind = beat_bias;
            default:  beat.kind = beat_w;
        endcase
        beat.idx = ct_idx;
        beat.tile = built;
        beat.row_last = (state == feed_w) && ct_last;
        beat.job_last = beat.row_last && (dim_t'(w_row + 1'b1) == rows);
    end

    // ============================
    // Tile payload
    // ============================

    always_ff @(posedge clk) begin
        if (vec_read_valid && (state == load_x || state == load_b)) begin
            local_tile <= vec_read_tile;
        end else if (mat_read_valid && state == load_w) begin
            local_tile <= mat_read_tile;
        end
        // Keep the unread tail for the next compute tile
        if (need_tile) begin
            for (int j = 0; j < gemv_tile - 1; j++) begin
                if (int'(new_buf_idx) + j < tile_elems) begin
                    carry[j] <= local_tile[int'(new_buf_idx) + j];
                end
            end
        end
    end

    // ============================
    // Control FSM
    // ============================

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= idle;
            vec_read_en <= 1'b0;
            mat_read_en <= 1'b0;
            buf_idx <= '0;
            carry_cnt <= '0;
            bt_read <= '0;
            ct_idx <= '0;
            w_row <= '0;
            outstanding <= 1'b0;
        end else begin
            vec_read_en <= 1'b0;
            mat_read_en <= 1'b0;
            if (vec_read_en || mat_read_en) begin
                outstanding <= 1'b1;
            end else if (vec_read_valid || mat_read_valid) begin
                outstanding <= 1'b0;
            end
            case (state)
                idle: begin
                    if (start) begin
                        buf_idx <= '0;
                        carry_cnt <= '0;
                        bt_read <= '0;
                        ct_idx <= '0;
                        w_row <= '0;
                        vec_read_en <= 1'b1;
                        state <= load_x;
                    end
                end
                load_x, load_b: begin
                    if (vec_read_valid) begin
                        bt_read <= bt_read + 1'b1;
                        buf_idx <= '0;
                        state <= (state == load_x) ? stream_x : stream_b;
                    end
                end
                load_w: begin
                    if (mat_read_valid) begin
                        bt_read <= bt_read + 1'b1;
                        buf_idx <= '0;
                        state <= feed_w;
                    end
                end
                stream_x, stream_b, feed_w: begin
                    if (beat_valid) begin
                        ct_idx <= ct_idx + 1'b1;
                        buf_idx <= new_buf_idx;
                        carry_cnt <= '0;
                        if (ct_last) begin
                            // Leftover lanes at the end of a vector or row are padding
                            ct_idx <= '0;
                            bt_read <= '0;
                            buf_idx <= '0;
                            if (state == stream_x) begin
                                vec_read_en <= 1'b1;
                                state <= load_b;
                            end else if (state == stream_b || !beat.job_last) begin
                                w_row <= (state == feed_w) ? w_row + 1'b1 : '0;
                                mat_read_en <= 1'b1;
                                state <= load_w;
                            end else begin
                                state <= idle;
                            end
                        end else if (need_tile) begin
                            carry_cnt <= 2'(4'(tile_elems) - new_buf_idx);
                            if (state == feed_w) begin
                                mat_read_en <= 1'b1;
                                state <= load_w;
                            end else begin
                                vec_read_en <= 1'b1;
                                state <= (state == stream_x) ? load_x : load_b;
                            end
                        end
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // ============================
    // Checks
    // ============================

    // Nothing is pending at the memory between jobs
    a_idle_quiet: assert property (@(posedge clk) disable iff (rst)
        state == idle |-> !outstanding && !vec_read_en && !mat_read_en);

    // Memory sees one request at a time
    a_one_read: assert property (@(posedge clk) disable iff (rst)
        (vec_read_en || mat_read_en) |-> !outstanding);

endmodule

`default_nettype wire
